// File: hdl/cpuIsaPkg.sv
// Instruction-set constants: data and field widths, opcodes, ALU function codes
package cpuIsaPkg;

  localparam int dataWidth    = 16;
  localparam int regAddrWidth = 4;
  localparam int numRegs      = 16;

  localparam int opcodeWidth  = 4;  // Instruction bits 15:12
  localparam int immWidth     = 8;  // LLB/LHB byte and branch offset
  localparam int memOffWidth  = 4;  // LW/SW offset, sign extended
  localparam int shamtWidth   = 4;  // SLL/SRA amount

  localparam logic [opcodeWidth-1:0] opAdd = 4'h0;
  localparam logic [opcodeWidth-1:0] opSub = 4'h1;
  localparam logic [opcodeWidth-1:0] opAnd = 4'h2;
  localparam logic [opcodeWidth-1:0] opXor = 4'h3;
  localparam logic [opcodeWidth-1:0] opSll = 4'h4;
  localparam logic [opcodeWidth-1:0] opSra = 4'h5;
  localparam logic [opcodeWidth-1:0] opLw  = 4'h6;
  localparam logic [opcodeWidth-1:0] opSw  = 4'h7;
  localparam logic [opcodeWidth-1:0] opLlb = 4'h8;
  localparam logic [opcodeWidth-1:0] opLhb = 4'h9;
  localparam logic [opcodeWidth-1:0] opBz  = 4'hA;
  localparam logic [opcodeWidth-1:0] opBnz = 4'hB;
  localparam logic [opcodeWidth-1:0] opHlt = 4'hF;  // 4'hC..4'hE act as no-ops

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluXor,
    aluSll,
    aluSra,
    aluPassB
  } aluOpT;

endpackage

// File: hdl/cpuBusPkg.sv
// Wishbone bus widths and control FSM state encoding
package cpuBusPkg;

  localparam int busAddrWidth = 16;  // Word address
  localparam int busDataWidth = 16;

  typedef enum logic [2:0] {
    idle,
    fetch,
    execute,
    memory,
    writeback,
    halted
  } ctrlStateT;

endpackage

// File: hdl/registerFile.sv
// Register file with hardwired zero register, two read ports and one write port
module registerFile (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic [cpuIsaPkg::regAddrWidth-1:0] rdIdxA,
  input  logic [cpuIsaPkg::regAddrWidth-1:0] rdIdxB,
  input  logic [cpuIsaPkg::regAddrWidth-1:0] wrIdx,
  input  logic                               wrEn,
  input  logic [cpuIsaPkg::dataWidth-1:0]    wrData,
  output logic [cpuIsaPkg::dataWidth-1:0]    rdDataA,
  output logic [cpuIsaPkg::dataWidth-1:0]    rdDataB
);

  logic [cpuIsaPkg::dataWidth-1:0] regs [1:cpuIsaPkg::numRegs-1];  // No storage for r0

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < cpuIsaPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrIdx != '0)) begin
      regs[wrIdx] <= wrData;  // Writes to r0 dropped
    end
  end

  // Reads see the pre-write value during a write cycle
  assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
  assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

  wrIdxKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    wrEn |-> !$isunknown(wrIdx)
  ) else $error("register write with unknown index");

endmodule

// File: hdl/aluUnit.sv
// ALU for add, subtract, logic and shifts, with the registered zero flag
module aluUnit (
  input  logic                            clk,
  input  logic                            rstN,
  input  cpuIsaPkg::aluOpT                aluOp,
  input  logic [cpuIsaPkg::dataWidth-1:0] opA,
  input  logic [cpuIsaPkg::dataWidth-1:0] opB,
  input  logic                            flagEn,
  output logic [cpuIsaPkg::dataWidth-1:0] result,
  output logic                            zeroFlag
);

  logic [cpuIsaPkg::shamtWidth-1:0] shamt;

  assign shamt = opB[cpuIsaPkg::shamtWidth-1:0];

  always_comb begin
    case (aluOp)
      cpuIsaPkg::aluAdd: begin
        result = opA + opB;  // Wraps
      end
      cpuIsaPkg::aluSub: begin
        result = opA - opB;
      end
      cpuIsaPkg::aluAnd: begin
        result = opA & opB;
      end
      cpuIsaPkg::aluXor: begin
        result = opA ^ opB;
      end
      cpuIsaPkg::aluSll: begin
        result = opA << shamt;
      end
      cpuIsaPkg::aluSra: begin
        result = $signed(opA) >>> shamt;
      end
      cpuIsaPkg::aluPassB: begin
        result = opB;
      end
      default: begin
        result = opB;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      zeroFlag <= 1'b0;
    end else if (flagEn) begin
      zeroFlag <= (result == '0);
    end
  end

endmodule

// File: hdl/programCounter.sv
// Program counter with increment and PC-relative branch load
module programCounter (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                advance,
  input  logic                                branch,
  input  logic [cpuIsaPkg::immWidth-1:0]      offset,
  output logic [cpuBusPkg::busAddrWidth-1:0]  pc
);

  localparam logic [cpuBusPkg::busAddrWidth-1:0] resetPc = '0;

  logic [cpuBusPkg::busAddrWidth-1:0] offsetExt;

  assign offsetExt = {{(cpuBusPkg::busAddrWidth - cpuIsaPkg::immWidth){offset[cpuIsaPkg::immWidth-1]}},
                      offset};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= resetPc;
    end else if (advance) begin
      pc <= pc + 1'b1 + (branch ? offsetExt : '0);  // Target is PC+1+offset
    end
  end

  branchNeedsAdvance: assert property (
    @(posedge clk) disable iff (!rstN)
    branch |-> advance
  ) else $error("branch strobe without advance");

endmodule

// File: hdl/cpuControl.sv
// Control FSM with instruction register, Wishbone master and writeback select
module cpuControl (
  input  logic                               clk,
  input  logic                               rstN,
  output logic                               wbCyc,
  output logic                               wbStb,
  output logic                               wbWe,
  output logic [cpuBusPkg::busAddrWidth-1:0] wbAdr,
  output logic [cpuBusPkg::busDataWidth-1:0] wbDatO,
  input  logic [cpuBusPkg::busDataWidth-1:0] wbDatI,
  input  logic                               wbAck,
  input  logic [cpuBusPkg::busAddrWidth-1:0] pc,
  output logic                               pcAdvance,
  output logic                               pcBranch,
  output logic [cpuIsaPkg::immWidth-1:0]     branchOffset,
  output logic [cpuIsaPkg::regAddrWidth-1:0] rdIdxA,
  output logic [cpuIsaPkg::regAddrWidth-1:0] rdIdxB,
  output logic [cpuIsaPkg::regAddrWidth-1:0] wrIdx,
  output logic                               wrEn,
  output logic [cpuIsaPkg::dataWidth-1:0]    wrData,
  input  logic [cpuIsaPkg::dataWidth-1:0]    rdDataA,
  input  logic [cpuIsaPkg::dataWidth-1:0]    rdDataB,
  output cpuIsaPkg::aluOpT                   aluOp,
  output logic [cpuIsaPkg::dataWidth-1:0]    opB,
  output logic                               flagEn,
  input  logic [cpuIsaPkg::dataWidth-1:0]    aluResult,
  input  logic                               zeroFlag,
  output logic                               halted
);

  cpuBusPkg::ctrlStateT state, nextState;

  logic [cpuBusPkg::busDataWidth-1:0]  ir;
  logic [cpuIsaPkg::dataWidth-1:0]     loadData;
  logic [cpuIsaPkg::opcodeWidth-1:0]   opcode;
  logic [cpuIsaPkg::regAddrWidth-1:0]  rdField;
  logic [cpuIsaPkg::regAddrWidth-1:0]  rsField;
  logic [cpuIsaPkg::regAddrWidth-1:0]  rtField;
  logic [cpuIsaPkg::immWidth-1:0]      imm;
  logic                                isMemOp;
  logic                                writesReg;
  logic                                branchTaken;

  // Layout: op[15:12] rd[11:8] rs[7:4] rt/offset/shamt[3:0], imm[7:0]
  assign opcode  = ir[15:12];
  assign rdField = ir[11:8];
  assign rsField = ir[7:4];
  assign rtField = ir[3:0];
  assign imm     = ir[cpuIsaPkg::immWidth-1:0];

  assign isMemOp   = (opcode == cpuIsaPkg::opLw) || (opcode == cpuIsaPkg::opSw);
  assign writesReg = opcode inside {cpuIsaPkg::opAdd, cpuIsaPkg::opSub, cpuIsaPkg::opAnd,
                                    cpuIsaPkg::opXor, cpuIsaPkg::opSll, cpuIsaPkg::opSra,
                                    cpuIsaPkg::opLlb, cpuIsaPkg::opLhb};
  assign branchTaken = ((opcode == cpuIsaPkg::opBz) && zeroFlag) ||
                       ((opcode == cpuIsaPkg::opBnz) && !zeroFlag);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= cpuBusPkg::idle;
      ir    <= '0;
    end else begin
      state <= nextState;
      if ((state == cpuBusPkg::fetch) && wbAck) begin
        ir <= wbDatI;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == cpuBusPkg::memory) && wbAck && !wbWe) begin
      loadData <= wbDatI;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cpuBusPkg::idle: begin
        nextState = cpuBusPkg::fetch;
      end
      cpuBusPkg::fetch: begin
        if (wbAck) begin
          nextState = cpuBusPkg::execute;
        end
      end
      cpuBusPkg::execute: begin
        if (opcode == cpuIsaPkg::opHlt) begin
          nextState = cpuBusPkg::halted;
        end else if (isMemOp) begin
          nextState = cpuBusPkg::memory;
        end else if (writesReg) begin
          nextState = cpuBusPkg::writeback;
        end else begin
          nextState = cpuBusPkg::fetch;  // Branches and no-ops
        end
      end
      cpuBusPkg::memory: begin
        if (wbAck) begin
          nextState = wbWe ? cpuBusPkg::fetch : cpuBusPkg::writeback;
        end
      end
      cpuBusPkg::writeback: begin
        nextState = cpuBusPkg::fetch;
      end
      default: begin
        nextState = state;  // Halted until reset
      end
    endcase
  end

  always_comb begin
    case (opcode)
      cpuIsaPkg::opAdd, cpuIsaPkg::opLw, cpuIsaPkg::opSw: aluOp = cpuIsaPkg::aluAdd;
      cpuIsaPkg::opSub: aluOp = cpuIsaPkg::aluSub;
      cpuIsaPkg::opAnd: aluOp = cpuIsaPkg::aluAnd;
      cpuIsaPkg::opXor: aluOp = cpuIsaPkg::aluXor;
      cpuIsaPkg::opSll: aluOp = cpuIsaPkg::aluSll;
      cpuIsaPkg::opSra: aluOp = cpuIsaPkg::aluSra;
      default: aluOp = cpuIsaPkg::aluPassB;
    endcase
  end

  always_comb begin
    case (opcode)
      cpuIsaPkg::opSll, cpuIsaPkg::opSra: begin
        opB = {{(cpuIsaPkg::dataWidth - cpuIsaPkg::shamtWidth){1'b0}},
               rtField[cpuIsaPkg::shamtWidth-1:0]};
      end
      cpuIsaPkg::opLw, cpuIsaPkg::opSw: begin
        opB = {{(cpuIsaPkg::dataWidth - cpuIsaPkg::memOffWidth){rtField[cpuIsaPkg::memOffWidth-1]}},
               rtField[cpuIsaPkg::memOffWidth-1:0]};
      end
      default: begin
        opB = rdDataB;
      end
    endcase
  end

  always_comb begin
    case (opcode)
      cpuIsaPkg::opLw:  wrData = loadData;
      cpuIsaPkg::opLlb: wrData = {rdDataB[cpuIsaPkg::dataWidth-1:cpuIsaPkg::immWidth], imm};
      cpuIsaPkg::opLhb: wrData = {imm, rdDataB[cpuIsaPkg::immWidth-1:0]};
      default:          wrData = aluResult;
    endcase
  end

  // Port B reads rd for store data and byte merge
  assign rdIdxA = rsField;
  assign rdIdxB = (opcode inside {cpuIsaPkg::opSw, cpuIsaPkg::opLlb, cpuIsaPkg::opLhb}) ?
                  rdField : rtField;
  assign wrIdx  = rdField;
  assign wrEn   = (state == cpuBusPkg::writeback);
  assign flagEn = (state == cpuBusPkg::execute) &&
                  (opcode inside {cpuIsaPkg::opAdd, cpuIsaPkg::opSub,
                                  cpuIsaPkg::opAnd, cpuIsaPkg::opXor});

  assign pcAdvance    = (state == cpuBusPkg::execute) && (opcode != cpuIsaPkg::opHlt);
  assign pcBranch     = (state == cpuBusPkg::execute) && branchTaken;
  assign branchOffset = imm;

  assign wbCyc  = (state == cpuBusPkg::fetch) || (state == cpuBusPkg::memory);
  assign wbStb  = wbCyc;
  assign wbWe   = (state == cpuBusPkg::memory) && (opcode == cpuIsaPkg::opSw);
  assign wbAdr  = (state == cpuBusPkg::fetch) ? pc : aluResult;
  assign wbDatO = rdDataB;
  assign halted = (state == cpuBusPkg::halted);

  stbMatchesCyc: assert property (
    @(posedge clk) disable iff (!rstN)
    wbStb == wbCyc
  ) else $error("wbStb differs from wbCyc");

  // Request must hold until the slave acks
  busHoldUntilAck: assert property (
    @(posedge clk) disable iff (!rstN)
    (wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatO))
  ) else $error("bus request changed before wbAck");

endmodule

// File: hdl/cpuCore.sv
// Processor top level joining control, register file, ALU and program counter
module cpuCore (
  input  logic                               clk,
  input  logic                               rstN,
  output logic                               wbCyc,
  output logic                               wbStb,
  output logic                               wbWe,
  output logic [cpuBusPkg::busAddrWidth-1:0] wbAdr,
  output logic [cpuBusPkg::busDataWidth-1:0] wbDatO,
  input  logic [cpuBusPkg::busDataWidth-1:0] wbDatI,
  input  logic                               wbAck,
  output logic                               halted
);

  logic [cpuBusPkg::busAddrWidth-1:0] pc;
  logic                               pcAdvance;
  logic                               pcBranch;
  logic [cpuIsaPkg::immWidth-1:0]     branchOffset;
  logic [cpuIsaPkg::regAddrWidth-1:0] rdIdxA;
  logic [cpuIsaPkg::regAddrWidth-1:0] rdIdxB;
  logic [cpuIsaPkg::regAddrWidth-1:0] wrIdx;
  logic                               wrEn;
  logic [cpuIsaPkg::dataWidth-1:0]    wrData;
  logic [cpuIsaPkg::dataWidth-1:0]    rdDataA;
  logic [cpuIsaPkg::dataWidth-1:0]    rdDataB;
  cpuIsaPkg::aluOpT                   aluOp;
  logic [cpuIsaPkg::dataWidth-1:0]    opB;
  logic                               flagEn;
  logic [cpuIsaPkg::dataWidth-1:0]    aluResult;
  logic                               zeroFlag;

  cpuControl cpuControl_inst (
    .clk          (clk),
    .rstN         (rstN),
    .wbCyc        (wbCyc),
    .wbStb        (wbStb),
    .wbWe         (wbWe),
    .wbAdr        (wbAdr),
    .wbDatO       (wbDatO),
    .wbDatI       (wbDatI),
    .wbAck        (wbAck),
    .pc           (pc),
    .pcAdvance    (pcAdvance),
    .pcBranch     (pcBranch),
    .branchOffset (branchOffset),
    .rdIdxA       (rdIdxA),
    .rdIdxB       (rdIdxB),
    .wrIdx        (wrIdx),
    .wrEn         (wrEn),
    .wrData       (wrData),
    .rdDataA      (rdDataA),
    .rdDataB      (rdDataB),
    .aluOp        (aluOp),
    .opB          (opB),
    .flagEn       (flagEn),
    .aluResult    (aluResult),
    .zeroFlag     (zeroFlag),
    .halted       (halted)
  );

  registerFile registerFile_inst (
    .clk     (clk),
    .rstN    (rstN),
    .rdIdxA  (rdIdxA),
    .rdIdxB  (rdIdxB),
    .wrIdx   (wrIdx),
    .wrEn    (wrEn),
    .wrData  (wrData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  aluUnit aluUnit_inst (
    .clk      (clk),
    .rstN     (rstN),
    .aluOp    (aluOp),
    .opA      (rdDataA),
    .opB      (opB),
    .flagEn   (flagEn),
    .result   (aluResult),
    .zeroFlag (zeroFlag)
  );

  programCounter programCounter_inst (
    .clk     (clk),
    .rstN    (rstN),
    .advance (pcAdvance),
    .branch  (pcBranch),
    .offset  (branchOffset),
    .pc      (pc)
  );

endmodule

// File: verif/wbMemoryModel.sv
// Wishbone classic slave memory with random wait states and a background fill
module wbMemoryModel (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               wbCyc,
  input  logic                               wbStb,
  input  logic                               wbWe,
  input  logic [cpuBusPkg::busAddrWidth-1:0] wbAdr,
  input  logic [cpuBusPkg::busDataWidth-1:0] wbDatWr,
  output logic [cpuBusPkg::busDataWidth-1:0] wbDatRd,
  output logic                               wbAck
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int memDepth = 256;
  localparam int maxWait  = 3;

  logic [cpuBusPkg::busDataWidth-1:0] mem [0:memDepth-1];
  logic [7:0]                         idx;
  logic                               busy;
  logic [1:0]                         waitLeft;

  assign idx = wbAdr[7:0];  // Upper address bits ignored

  initial begin
    for (int a = 0; a < memDepth; a++) begin
      mem[a] = {~8'(a), 8'(a)};  // Pattern from the full index
    end
  end

  // Acts on the falling edge so the core samples a settled wbAck
  always @(negedge clk or negedge rstN) begin
    logic [1:0] waits;
    if (!rstN) begin
      wbAck    <= 1'b0;
      wbDatRd  <= '0;
      busy     <= 1'b0;
      waitLeft <= '0;
    end else if (wbAck) begin
      wbAck <= 1'b0;  // Cycle closed on the last rising edge
    end else if (wbCyc && wbStb) begin
      waits = busy ? waitLeft : 2'($urandom_range(maxWait, 0));
      if (waits == '0) begin
        wbAck <= 1'b1;
        busy  <= 1'b0;
        if (wbWe) begin
          mem[idx] = wbDatWr;
        end else begin
          wbDatRd <= mem[idx];
        end
      end else begin
        busy     <= 1'b1;
        waitLeft <= waits - 1'b1;
      end
    end
  end

endmodule

// File: verif/cpuCoreTb.sv
// Testbench top with clock, reset, test program, expected store list and checking assertions
module cpuCoreTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          maxCycles = 2000;
  localparam int          haltQuiet = 20;
  localparam logic [15:0] storeBase = 16'h0040;
  localparam logic [15:0] dataBase  = 16'h0080;
  localparam logic [15:0] memPtr    = 16'h0084;
  localparam logic [15:0] skipAdr   = 16'h0083;  // Store in the skipped branch path
  localparam logic [15:0] valA      = 16'h1234;
  localparam logic [15:0] valB      = 16'h0FF0;
  localparam logic [15:0] valC      = 16'hF248;

  logic                               clk;
  logic                               rstN;
  logic                               wbCyc;
  logic                               wbStb;
  logic                               wbWe;
  logic [cpuBusPkg::busAddrWidth-1:0] wbAdr;
  logic [cpuBusPkg::busDataWidth-1:0] wbDatO;
  logic [cpuBusPkg::busDataWidth-1:0] wbDatI;
  logic                               wbAck;
  logic                               halted;
  logic                               storeDone;
  logic                               seenCyc;
  int                                 storeIdx;
  int                                 numExpected;
  logic [15:0]                        expAdr [$];
  logic [15:0]                        expDat [$];
  string                              expName [$];
  logic [15:0]                        dataWords [16];

  cpuCore cpuCore_inst (
    .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck), .halted(halted)
  );

  wbMemoryModel memModel_inst (
    .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatWr(wbDatO), .wbDatRd(wbDatI), .wbAck(wbAck)
  );

  always #50 clk = ~clk;

  assign storeDone = wbCyc && wbWe && wbAck;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      storeIdx <= 0;
      seenCyc  <= 1'b0;
    end else begin
      if (storeDone) begin
        storeIdx <= storeIdx + 1;
      end
      if (wbCyc) begin
        seenCyc <= 1'b1;
      end
    end
  end

  function automatic logic [15:0] encReg(logic [3:0] op, logic [3:0] rd, logic [3:0] rs,
                                         logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] encImm(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  task automatic stopOnFailure(string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic reportMismatch(string testName, logic [15:0] expected, logic [15:0] actual);
    stopOnFailure($sformatf("[ERROR] %s: expected %h, actual %h", testName, expected, actual));
  endtask

  task automatic addExpectedStore(string testName, logic [15:0] adr, logic [15:0] dat);
    expName.push_back(testName);
    expAdr.push_back(adr);
    expDat.push_back(dat);
  endtask

  task automatic loadProgram();
    logic [15:0] prog [$];
    prog = {
      encImm(cpuIsaPkg::opLlb, 4'd1, valA[7:0]),
      encImm(cpuIsaPkg::opLhb, 4'd1, valA[15:8]),
      encImm(cpuIsaPkg::opLlb, 4'd2, valB[7:0]),
      encImm(cpuIsaPkg::opLhb, 4'd2, valB[15:8]),
      encImm(cpuIsaPkg::opLlb, 4'd10, storeBase[7:0]),
      encReg(cpuIsaPkg::opAdd, 4'd3, 4'd1, 4'd2),
      encReg(cpuIsaPkg::opSw, 4'd3, 4'd10, 4'd0),
      encReg(cpuIsaPkg::opSub, 4'd4, 4'd1, 4'd2),
      encReg(cpuIsaPkg::opSw, 4'd4, 4'd10, 4'd1),
      encReg(cpuIsaPkg::opAnd, 4'd5, 4'd1, 4'd2),
      encReg(cpuIsaPkg::opSw, 4'd5, 4'd10, 4'd2),
      encReg(cpuIsaPkg::opXor, 4'd6, 4'd1, 4'd2),
      encReg(cpuIsaPkg::opSw, 4'd6, 4'd10, 4'd3),
      encReg(cpuIsaPkg::opSll, 4'd7, 4'd1, 4'd5),
      encReg(cpuIsaPkg::opSw, 4'd7, 4'd10, 4'd4),
      encImm(cpuIsaPkg::opLlb, 4'd8, valC[7:0]),
      encImm(cpuIsaPkg::opLhb, 4'd8, valC[15:8]),
      encReg(cpuIsaPkg::opSra, 4'd13, 4'd8, 4'd3),
      encReg(cpuIsaPkg::opSw, 4'd13, 4'd10, 4'd5),
      encImm(cpuIsaPkg::opLlb, 4'd0, 8'h55),     // r0 must stay zero
      encReg(cpuIsaPkg::opSw, 4'd0, 4'd10, 4'd6),
      encImm(cpuIsaPkg::opLlb, 4'd11, memPtr[7:0]),
      encReg(cpuIsaPkg::opLw, 4'd12, 4'd11, 4'hE),  // Offset -2
      encReg(cpuIsaPkg::opSw, 4'd12, 4'd11, 4'd3),
      encReg(cpuIsaPkg::opSub, 4'd9, 4'd1, 4'd1),
      encImm(cpuIsaPkg::opBz, 4'd0, 8'd1),
      encReg(cpuIsaPkg::opSw, 4'd1, 4'd11, 4'hF),   // Skipped
      encReg(cpuIsaPkg::opSw, 4'd2, 4'd10, 4'd7),
      encImm(cpuIsaPkg::opBnz, 4'd0, 8'd1),
      encReg(cpuIsaPkg::opSw, 4'd4, 4'd11, 4'h8),   // Offset -8
      encReg(cpuIsaPkg::opHlt, 4'd0, 4'd0, 4'd0)
    };
    foreach (prog[i]) begin
      memModel_inst.mem[i] = prog[i];
    end
    for (int i = 0; i < 16; i++) begin
      dataWords[i] = 16'($urandom);
      memModel_inst.mem[dataBase + i] = dataWords[i];
    end
  endtask

  task automatic buildStoreList();
    logic [15:0] loadAdr;
    loadAdr = memPtr - 16'd2;
    addExpectedStore("add", storeBase, valA + valB);
    addExpectedStore("sub", storeBase + 16'd1, valA - valB);
    addExpectedStore("and", storeBase + 16'd2, valA & valB);
    addExpectedStore("xor", storeBase + 16'd3, valA ^ valB);
    addExpectedStore("sll", storeBase + 16'd4, valA << 5);
    addExpectedStore("sra", storeBase + 16'd5, $signed(valC) >>> 3);
    addExpectedStore("zeroReg", storeBase + 16'd6, 16'h0000);
    addExpectedStore("memRoundTrip", memPtr + 16'd3, dataWords[loadAdr - dataBase]);
    addExpectedStore("branchTaken", storeBase + 16'd7, valB);
    addExpectedStore("branchNotTaken", memPtr - 16'd8, valA - valB);
    numExpected = expAdr.size();
  endtask

  resetBusIdle: assert property (@(posedge clk) (!rstN || $rose(rstN)) |-> !wbCyc)
    else stopOnFailure("wbCyc was high during reset or on the first edge after it");

  firstFetchAdr: assert property (@(posedge clk) disable iff (!rstN)
    (wbCyc && !seenCyc) |-> (wbAdr == '0))
    else reportMismatch("firstFetch", 16'h0000, $sampled(wbAdr));

  stbFollowsCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb == wbCyc)
    else reportMismatch("wbStb", 16'($sampled(wbCyc)), 16'($sampled(wbStb)));

  storeCountLimit: assert property (@(posedge clk) disable iff (!rstN)
    storeDone |-> (storeIdx < numExpected))
    else stopOnFailure("the core made more stores than expected");

  storeAdrMatch: assert property (@(posedge clk) disable iff (!rstN)
    storeDone |-> (wbAdr == expAdr[storeIdx]))
    else reportMismatch({expName[$sampled(storeIdx)], " address"},
                        expAdr[$sampled(storeIdx)], $sampled(wbAdr));

  storeDatMatch: assert property (@(posedge clk) disable iff (!rstN)
    storeDone |-> (wbDatO == expDat[storeIdx]))
    else reportMismatch({expName[$sampled(storeIdx)], " data"},
                        expDat[$sampled(storeIdx)], $sampled(wbDatO));

  noSkippedStore: assert property (@(posedge clk) disable iff (!rstN)
    storeDone |-> (wbAdr != skipAdr))
    else stopOnFailure("a store from the skipped branch path reached the bus");

  haltBusQuiet: assert property (@(posedge clk) disable iff (!rstN) halted |-> !wbCyc)
    else stopOnFailure("a bus cycle started after HLT");

  haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
    else stopOnFailure("halted dropped before reset");

  initial begin
    int cycles;
    void'($urandom(32'h15277ba5));
    clk  = 1'b0;
    rstN = 1'b0;
    @(negedge clk);
    loadProgram();
    buildStoreList();
    @(negedge clk);
    rstN = 1'b1;
    cycles = 0;
    while (!halted && (cycles < maxCycles)) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      stopOnFailure("Timeout: the core did not reach HLT");
    end
    repeat (haltQuiet) @(negedge clk);
    if (storeIdx != numExpected) begin
      stopOnFailure($sformatf("[ERROR] storeCount: expected %0d, actual %0d",
                              numExpected, storeIdx));
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// File: build.f
hdl/cpuIsaPkg.sv
hdl/cpuBusPkg.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/programCounter.sv
hdl/cpuControl.sv
hdl/cpuCore.sv
verif/wbMemoryModel.sv
verif/cpuCoreTb.sv

// File: sim.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cpuCoreTb -f build.f -o cpuCoreSim || exit 1
./obj_dir/cpuCoreSim > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
